// ==== verilog/sw_cfg_pkg.sv ====
`default_nettype none

package sw_cfg_pkg;

    // datapath
    localparam int DATA_LEN = 32;
    localparam int ADDR_LEN = 32;
    localparam int RRF_SEL = 6;

    // station sizes
    localparam int ALU_ENT_NUM = 8;
    localparam int ALU_ENT_SEL = 3;
    localparam int LDST_ENT_NUM = 4;
    localparam int LDST_ENT_SEL = 2;

    localparam int RESULT_BUS_NUM = 2;
    localparam int ALU_OP_WIDTH = 4;

    // age key is {not_ready, phase_eq, tag}
    localparam int KEY_LEN = RRF_SEL + 2;

endpackage

`default_nettype wire

// ==== verilog/sw_types_pkg.sv ====
`default_nettype none

package sw_types_pkg;

    import sw_cfg_pkg::*;

    // data, or producer tag in the low bits while valid is low
    typedef struct packed {
        logic [DATA_LEN-1:0] data;
        logic                valid;
    } opnd_t;

    typedef struct packed {
        logic       store;
        logic [1:0] size;
        logic       is_unsigned;
    } mem_kind_t;

    typedef union packed {
        logic [ALU_OP_WIDTH-1:0] alu_op;
        mem_kind_t               mem_kind;
    } op_u;

    typedef struct packed {
        logic                valid;
        logic                is_mem;
        logic [ADDR_LEN-1:0] pc;
        opnd_t               src1;
        opnd_t               src2;
        logic [DATA_LEN-1:0] imm;
        logic [RRF_SEL-1:0]  rrf_tag;
        logic                dst_val;
        op_u                 op;
    } dp_slot_t;

    typedef struct packed {
        logic                valid;
        logic [RRF_SEL-1:0]  tag;
        logic [DATA_LEN-1:0] data;
    } result_t;

    typedef struct packed {
        logic [ADDR_LEN-1:0] pc;
        logic [DATA_LEN-1:0] op1;
        logic [DATA_LEN-1:0] op2;
        logic [DATA_LEN-1:0] imm;
        logic [RRF_SEL-1:0]  rrf_tag;
        logic                dst_val;
        op_u                 op;
    } issue_t;

    typedef struct packed {
        logic                busy;
        logic                phase;
        logic [ADDR_LEN-1:0] pc;
        opnd_t               src1;
        opnd_t               src2;
        logic [DATA_LEN-1:0] imm;
        logic [RRF_SEL-1:0]  rrf_tag;
        logic                dst_val;
        op_u                 op;
    } rs_entry_t;

    // snoop the result buses for a waiting operand
    function automatic opnd_t wake_opnd(opnd_t o, result_t [RESULT_BUS_NUM-1:0] res);
        opnd_t w;
        w = o;
        for (int i = 0; i < RESULT_BUS_NUM; i++) begin
            if (!w.valid && res[i].valid && res[i].tag == w.data[RRF_SEL-1:0]) begin
                w.data = res[i].data;
                w.valid = 1'b1;
            end
        end
        return w;
    endfunction

    function automatic rs_entry_t make_entry(dp_slot_t s, logic phase,
                                             result_t [RESULT_BUS_NUM-1:0] res);
        rs_entry_t e;
        e.busy = 1'b1;
        e.phase = phase;
        e.pc = s.pc;
        e.src1 = wake_opnd(s.src1, res);
        e.src2 = wake_opnd(s.src2, res);
        e.imm = s.imm;
        e.rrf_tag = s.rrf_tag;
        e.dst_val = s.dst_val;
        e.op = s.op;
        return e;
    endfunction

    function automatic issue_t to_issue(rs_entry_t e);
        issue_t t;
        t.pc = e.pc;
        t.op1 = e.src1.data;
        t.op2 = e.src2.data;
        t.imm = e.imm;
        t.rrf_tag = e.rrf_tag;
        t.dst_val = e.dst_val;
        t.op = e.op;
        return t;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/alloc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module alloc_unit #(
    parameter int ENT_NUM = 8
) (
    input  wire  [ENT_NUM-1:0]         busy_i,
    input  wire  [1:0]                 req_num_i,
    output logic [$clog2(ENT_NUM)-1:0] free_1_o,
    output logic [$clog2(ENT_NUM)-1:0] free_2_o,
    output logic                       en_1_o,
    output logic                       en_2_o,
    output logic                       enough_o
);

    logic found_1;
    logic found_2;

    // lowest and second lowest free entries
    always_comb begin
        free_1_o = '0;
        free_2_o = '0;
        found_1 = 1'b0;
        found_2 = 1'b0;
        for (int i = 0; i < ENT_NUM; i++) begin
            if (!busy_i[i]) begin
                if (!found_1) begin
                    free_1_o = i[$clog2(ENT_NUM)-1:0];
                    found_1 = 1'b1;
                end else if (!found_2) begin
                    free_2_o = i[$clog2(ENT_NUM)-1:0];
                    found_2 = 1'b1;
                end
            end
        end
    end

    assign en_1_o = found_1 & (req_num_i != 2'd0);
    assign en_2_o = found_2 & (req_num_i == 2'd2);

    assign enough_o = (req_num_i == 2'd0)
                    | ((req_num_i == 2'd1) & found_1)
                    | ((req_num_i == 2'd2) & found_2);

endmodule

`default_nettype wire

// ==== verilog/oldest_finder.sv ====
`timescale 1ns/100ps
`default_nettype none

module oldest_finder (
    input  wire  [sw_cfg_pkg::ALU_ENT_NUM-1:0][sw_cfg_pkg::KEY_LEN-1:0] key_vec_i,
    output logic [sw_cfg_pkg::ALU_ENT_SEL-1:0]                          oldest_idx_o,
    output logic [sw_cfg_pkg::KEY_LEN-1:0]                              oldest_key_o
);

    import sw_cfg_pkg::*;

    // heap order with node n fed by 2n+1 and 2n+2 and the leaves last
    logic [KEY_LEN-1:0]     node_key [2*ALU_ENT_NUM-1];
    logic [ALU_ENT_SEL-1:0] node_idx [2*ALU_ENT_NUM-1];

    for (genvar i = 0; i < ALU_ENT_NUM; i++) begin : g_leaf
        assign node_key[ALU_ENT_NUM-1+i] = key_vec_i[i];
        assign node_idx[ALU_ENT_NUM-1+i] = ALU_ENT_SEL'(i);
    end

    for (genvar n = 0; n < ALU_ENT_NUM-1; n++) begin : g_node
        logic take_right;
        // left side holds the lower indices, so it keeps ties
        assign take_right = node_key[2*n+2] < node_key[2*n+1];
        assign node_key[n] = take_right ? node_key[2*n+2] : node_key[2*n+1];
        assign node_idx[n] = take_right ? node_idx[2*n+2] : node_idx[2*n+1];
    end

    assign oldest_idx_o = node_idx[0];
    assign oldest_key_o = node_key[0];

endmodule

`default_nettype wire

// ==== verilog/rs_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_alu (
    input  wire                                   clk_i,
    input  wire                                   reset_i,
    input  wire                                   next_rrf_cycle_i,
    input  wire                                   we_1_i,
    input  wire                                   we_2_i,
    input  wire  sw_types_pkg::dp_slot_t          wslot_1_i,
    input  wire  sw_types_pkg::dp_slot_t          wslot_2_i,
    input  wire  [sw_cfg_pkg::ALU_ENT_SEL-1:0]    waddr_1_i,
    input  wire  [sw_cfg_pkg::ALU_ENT_SEL-1:0]    waddr_2_i,
    input  wire  sw_types_pkg::result_t [sw_cfg_pkg::RESULT_BUS_NUM-1:0] result_i,
    output logic [sw_cfg_pkg::ALU_ENT_NUM-1:0]    busy_o,
    output sw_types_pkg::issue_t                  issue_o,
    output logic                                  issue_valid_o
);

    import sw_cfg_pkg::*;
    import sw_types_pkg::*;

    rs_entry_t                          ent [ALU_ENT_NUM];
    logic                               cur_phase;
    logic [ALU_ENT_NUM-1:0][KEY_LEN-1:0] key_vec;
    logic [ALU_ENT_SEL-1:0]             oldest_idx;
    logic [KEY_LEN-1:0]                 oldest_key;

    always_comb begin
        for (int i = 0; i < ALU_ENT_NUM; i++) begin
            busy_o[i] = ent[i].busy;
            // empty or waiting entries sort last
            key_vec[i] = {~(ent[i].busy & ent[i].src1.valid & ent[i].src2.valid),
                          ent[i].phase == cur_phase,
                          ent[i].rrf_tag};
        end
    end

    oldest_finder u_oldest_finder (
        .key_vec_i   (key_vec),
        .oldest_idx_o(oldest_idx),
        .oldest_key_o(oldest_key)
    );

    assign issue_valid_o = ~oldest_key[KEY_LEN-1];
    assign issue_o = to_issue(ent[oldest_idx]);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cur_phase <= 1'b0;
            for (int i = 0; i < ALU_ENT_NUM; i++) begin
                ent[i].busy <= 1'b0;
                ent[i].phase <= 1'b0;
            end
        end else begin
            if (next_rrf_cycle_i) begin
                cur_phase <= ~cur_phase;
            end
            for (int i = 0; i < ALU_ENT_NUM; i++) begin
                ent[i].src1 <= wake_opnd(ent[i].src1, result_i);
                ent[i].src2 <= wake_opnd(ent[i].src2, result_i);
                if (issue_valid_o && oldest_idx == ALU_ENT_SEL'(i)) begin
                    ent[i].busy <= 1'b0;
                end
            end
            // writes only target free entries
            if (we_1_i) begin
                ent[waddr_1_i] <= make_entry(wslot_1_i, cur_phase, result_i);
            end
            if (we_2_i) begin
                ent[waddr_2_i] <= make_entry(wslot_2_i, cur_phase, result_i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rs_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_mem (
    input  wire                          clk_i,
    input  wire                          reset_i,
    input  wire                          next_rrf_cycle_i,
    input  wire                          we_1_i,
    input  wire                          we_2_i,
    input  wire  sw_types_pkg::dp_slot_t wslot_1_i,
    input  wire  sw_types_pkg::dp_slot_t wslot_2_i,
    input  wire  sw_types_pkg::result_t [sw_cfg_pkg::RESULT_BUS_NUM-1:0] result_i,
    output logic [2:0]                   free_cnt_o,
    output sw_types_pkg::issue_t         issue_o,
    output logic                         issue_valid_o
);

    import sw_cfg_pkg::*;
    import sw_types_pkg::*;

    rs_entry_t               ent [LDST_ENT_NUM];
    logic                    cur_phase;
    logic [LDST_ENT_SEL-1:0] head;
    logic [LDST_ENT_SEL-1:0] tail;
    logic [LDST_ENT_SEL-1:0] tail_plus_1;

    assign tail_plus_1 = tail + LDST_ENT_SEL'(1);

    always_comb begin
        free_cnt_o = '0;
        for (int i = 0; i < LDST_ENT_NUM; i++) begin
            free_cnt_o = free_cnt_o + {2'b00, ~ent[i].busy};
        end
    end

    // only the head may go, younger ready entries wait behind it
    assign issue_valid_o = ent[head].busy & ent[head].src1.valid & ent[head].src2.valid;
    assign issue_o = to_issue(ent[head]);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cur_phase <= 1'b0;
            head <= '0;
            tail <= '0;
            for (int i = 0; i < LDST_ENT_NUM; i++) begin
                ent[i].busy <= 1'b0;
                ent[i].phase <= 1'b0;
            end
        end else begin
            if (next_rrf_cycle_i) begin
                cur_phase <= ~cur_phase;
            end
            for (int i = 0; i < LDST_ENT_NUM; i++) begin
                ent[i].src1 <= wake_opnd(ent[i].src1, result_i);
                ent[i].src2 <= wake_opnd(ent[i].src2, result_i);
            end
            if (issue_valid_o) begin
                ent[head].busy <= 1'b0;
                head <= head + LDST_ENT_SEL'(1);
            end
            if (we_1_i) begin
                ent[tail] <= make_entry(wslot_1_i, cur_phase, result_i);
            end
            if (we_2_i) begin
                ent[tail_plus_1] <= make_entry(wslot_2_i, cur_phase, result_i);
            end
            tail <= tail + LDST_ENT_SEL'(we_1_i) + LDST_ENT_SEL'(we_2_i);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sw_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module sw_unit (
    input  wire                          clk_i,
    input  wire                          reset_i,
    input  wire  sw_types_pkg::dp_slot_t dp_slot_1_i,
    input  wire  sw_types_pkg::dp_slot_t dp_slot_2_i,
    input  wire                          stall_dp_i,
    input  wire                          kill_dp_i,
    input  wire                          next_rrf_cycle_i,
    input  wire  sw_types_pkg::result_t [sw_cfg_pkg::RESULT_BUS_NUM-1:0] exe_result_i,
    output logic                         allocatable_o,
    output sw_types_pkg::issue_t         alu_issue_o,
    output logic                         alu_issue_valid_o,
    output sw_types_pkg::issue_t         mem_issue_o,
    output logic                         mem_issue_valid_o
);

    import sw_cfg_pkg::*;
    import sw_types_pkg::*;

    logic                   slot_1_alu;
    logic                   slot_2_alu;
    logic                   slot_1_mem;
    logic                   slot_2_mem;
    logic [1:0]             alu_cnt;
    logic [1:0]             mem_cnt;
    logic [ALU_ENT_NUM-1:0] alu_busy;
    logic [ALU_ENT_SEL-1:0] alu_free_1;
    logic [ALU_ENT_SEL-1:0] alu_free_2;
    logic                   alu_en_1;
    logic                   alu_en_2;
    logic                   alu_enough;
    logic [2:0]             mem_free_cnt;
    logic                   accept;
    dp_slot_t               alu_wslot_1;
    dp_slot_t               mem_wslot_1;

    assign slot_1_alu = dp_slot_1_i.valid & ~dp_slot_1_i.is_mem;
    assign slot_2_alu = dp_slot_2_i.valid & ~dp_slot_2_i.is_mem;
    assign slot_1_mem = dp_slot_1_i.valid & dp_slot_1_i.is_mem;
    assign slot_2_mem = dp_slot_2_i.valid & dp_slot_2_i.is_mem;

    assign alu_cnt = {1'b0, slot_1_alu} + {1'b0, slot_2_alu};
    assign mem_cnt = {1'b0, slot_1_mem} + {1'b0, slot_2_mem};

    alloc_unit #(
        .ENT_NUM(ALU_ENT_NUM)
    ) u_alloc_unit (
        .busy_i   (alu_busy),
        .req_num_i(alu_cnt),
        .free_1_o (alu_free_1),
        .free_2_o (alu_free_2),
        .en_1_o   (alu_en_1),
        .en_2_o   (alu_en_2),
        .enough_o (alu_enough)
    );

    // both stations must take their share, or nothing is written
    assign allocatable_o = alu_enough & (mem_free_cnt >= {1'b0, mem_cnt});
    assign accept = ~stall_dp_i & ~kill_dp_i & allocatable_o;

    // first slot of a class takes write 1, a second one takes write 2
    assign alu_wslot_1 = slot_1_alu ? dp_slot_1_i : dp_slot_2_i;
    assign mem_wslot_1 = slot_1_mem ? dp_slot_1_i : dp_slot_2_i;

    rs_alu u_rs_alu (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .next_rrf_cycle_i(next_rrf_cycle_i),
        .we_1_i          (accept & alu_en_1),
        .we_2_i          (accept & alu_en_2),
        .wslot_1_i       (alu_wslot_1),
        .wslot_2_i       (dp_slot_2_i),
        .waddr_1_i       (alu_free_1),
        .waddr_2_i       (alu_free_2),
        .result_i        (exe_result_i),
        .busy_o          (alu_busy),
        .issue_o         (alu_issue_o),
        .issue_valid_o   (alu_issue_valid_o)
    );

    rs_mem u_rs_mem (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .next_rrf_cycle_i(next_rrf_cycle_i),
        .we_1_i          (accept & (slot_1_mem | slot_2_mem)),
        .we_2_i          (accept & slot_1_mem & slot_2_mem),
        .wslot_1_i       (mem_wslot_1),
        .wslot_2_i       (dp_slot_2_i),
        .result_i        (exe_result_i),
        .free_cnt_o      (mem_free_cnt),
        .issue_o         (mem_issue_o),
        .issue_valid_o   (mem_issue_valid_o)
    );

endmodule

`default_nettype wire

// ==== testbench/sw_unit_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module sw_unit_checker (
    input wire                          clk_i,
    input wire                          reset_i,
    input wire  sw_types_pkg::dp_slot_t dp_slot_1_i,
    input wire  sw_types_pkg::dp_slot_t dp_slot_2_i,
    input wire                          stall_dp_i,
    input wire                          kill_dp_i,
    input wire                          allocatable_o,
    input wire  sw_types_pkg::issue_t   alu_issue_o,
    input wire                          alu_issue_valid_o,
    input wire  sw_types_pkg::issue_t   mem_issue_o,
    input wire                          mem_issue_valid_o
);

    import sw_cfg_pkg::*;
    import sw_types_pkg::*;

    // tags of memory ops dispatched and not yet issued
    logic [RRF_SEL-1:0] tag_q [4];
    logic [1:0]         rd_ptr;
    logic [1:0]         wr_ptr;
    logic [2:0]         pend_cnt;
    logic               accept;
    logic               m1;
    logic               m2;

    assign accept = ~stall_dp_i & ~kill_dp_i & allocatable_o;
    assign m1 = accept & dp_slot_1_i.valid & dp_slot_1_i.is_mem;
    assign m2 = accept & dp_slot_2_i.valid & dp_slot_2_i.is_mem;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            pend_cnt <= '0;
        end else begin
            if (m1) begin
                tag_q[wr_ptr] <= dp_slot_1_i.rrf_tag;
            end
            if (m2) begin
                tag_q[wr_ptr + 2'(m1)] <= dp_slot_2_i.rrf_tag;
            end
            wr_ptr <= wr_ptr + 2'(m1) + 2'(m2);
            rd_ptr <= rd_ptr + 2'(mem_issue_valid_o);
            pend_cnt <= pend_cnt + 3'(m1) + 3'(m2) - 3'(mem_issue_valid_o);
        end
    end

    a_issue_idle_after_reset: assert property (@(posedge clk_i)
        reset_i |=> !alu_issue_valid_o && !mem_issue_valid_o)
        else $error("issue valid high right after reset");

    a_alloc_after_reset: assert property (@(posedge clk_i)
        reset_i |=> allocatable_o)
        else $error("allocatable low right after reset");

    a_no_x_payload: assert property (@(posedge clk_i) disable iff (reset_i)
        (alu_issue_valid_o |-> !$isunknown(alu_issue_o))
        and (mem_issue_valid_o |-> !$isunknown(mem_issue_o)))
        else $error("issue payload holds X while valid");

    a_mem_in_order: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_issue_valid_o |-> pend_cnt != 0 && mem_issue_o.rrf_tag == tag_q[rd_ptr])
        else $error("memory issue out of program order");

endmodule

bind sw_unit sw_unit_checker u_sw_unit_checker (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .dp_slot_1_i      (dp_slot_1_i),
    .dp_slot_2_i      (dp_slot_2_i),
    .stall_dp_i       (stall_dp_i),
    .kill_dp_i        (kill_dp_i),
    .allocatable_o    (allocatable_o),
    .alu_issue_o      (alu_issue_o),
    .alu_issue_valid_o(alu_issue_valid_o),
    .mem_issue_o      (mem_issue_o),
    .mem_issue_valid_o(mem_issue_valid_o)
);

`default_nettype wire

// ==== testbench/tb_sw_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_sw_unit;

    import sw_cfg_pkg::*;
    import sw_types_pkg::*;

    localparam int DISPATCH_CYCLES = 400;
    localparam int CYCLE_LIMIT = 20 * DISPATCH_CYCLES + 200;

    logic                               clk_i;
    logic                               reset_i;
    dp_slot_t                           dp_slot_1_i;
    dp_slot_t                           dp_slot_2_i;
    logic                               stall_dp_i;
    logic                               kill_dp_i;
    logic                               next_rrf_cycle_i;
    result_t [RESULT_BUS_NUM-1:0]       exe_result_i;
    logic                               allocatable_o;
    issue_t                             alu_issue_o;
    logic                               alu_issue_valid_o;
    issue_t                             mem_issue_o;
    logic                               mem_issue_valid_o;

    // copies of what is currently applied to the DUT
    dp_slot_t                     s1;
    dp_slot_t                     s2;
    logic                         st;
    logic                         kl;
    logic                         nrc;
    result_t [RESULT_BUS_NUM-1:0] rs;

    // reference model
    rs_entry_t   m_alu [ALU_ENT_NUM];
    rs_entry_t   m_mem [$];
    logic        m_phase;
    logic [31:0] lfsr;
    logic [5:0]  tag_base;
    int          cyc = 0;

    sw_unit sw_unit_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic opnd_t snoop(opnd_t o, result_t [RESULT_BUS_NUM-1:0] r);
        opnd_t w;
        w = o;
        for (int b = 0; b < RESULT_BUS_NUM; b++) begin
            if (!w.valid && r[b].valid && r[b].tag == w.data[RRF_SEL-1:0]) begin
                w = {r[b].data, 1'b1};
            end
        end
        return w;
    endfunction

    function automatic dp_slot_t rand_slot(logic [5:0] tag, logic en);
        dp_slot_t    s;
        logic [31:0] v;
        s.valid = en & (take_bits(2) != 0);
        s.is_mem = take_bits(2) == 0;
        s.pc = take_bits(32);
        s.src1.valid = take_bits(2) != 0;
        s.src1.data = take_bits(32);
        s.src2.valid = take_bits(2) != 0;
        s.src2.data = take_bits(32);
        s.imm = take_bits(32);
        s.rrf_tag = tag;
        s.dst_val = take_bits(1) != 0;
        v = take_bits(4);
        s.op.alu_op = v[3:0];
        return s;
    endfunction

    function automatic rs_entry_t new_entry(dp_slot_t s);
        rs_entry_t e;
        e = {1'b1, m_phase, s.pc, snoop(s.src1, rs), snoop(s.src2, rs),
             s.imm, s.rrf_tag, s.dst_val, s.op};
        return e;
    endfunction

    function automatic logic [KEY_LEN-1:0] age_key(rs_entry_t e);
        return {~(e.busy & e.src1.valid & e.src2.valid), e.phase == m_phase, e.rrf_tag};
    endfunction

    function automatic issue_t expect_issue(rs_entry_t e);
        return {e.pc, e.src1.data, e.src2.data, e.imm, e.rrf_tag, e.dst_val, e.op};
    endfunction

    function automatic int oldest_alu();
        int best;
        best = 0;
        for (int i = 1; i < ALU_ENT_NUM; i++) begin
            if (age_key(m_alu[i]) < age_key(m_alu[best])) begin
                best = i;
            end
        end
        return best;
    endfunction

    function automatic logic mem_ready();
        return m_mem.size() > 0 && m_mem[0].src1.valid && m_mem[0].src2.valid;
    endfunction

    function automatic logic model_alloc();
        int alu_free;
        int alu_n;
        int mem_n;
        alu_free = 0;
        for (int i = 0; i < ALU_ENT_NUM; i++) begin
            alu_free += int'(!m_alu[i].busy);
        end
        alu_n = int'(s1.valid & !s1.is_mem) + int'(s2.valid & !s2.is_mem);
        mem_n = int'(s1.valid & s1.is_mem) + int'(s2.valid & s2.is_mem);
        return alu_free >= alu_n && (LDST_ENT_NUM - m_mem.size()) >= mem_n;
    endfunction

    task automatic check_val(string name, logic [191:0] exp, logic [191:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_outputs();
        int                 best;
        logic [KEY_LEN-1:0] best_key;
        logic               alu_v;
        best = oldest_alu();
        best_key = age_key(m_alu[best]);
        alu_v = !best_key[KEY_LEN-1];
        check_val("allocatable", model_alloc(), allocatable_o);
        check_val("alu_issue_valid", alu_v, alu_issue_valid_o);
        if (alu_v) begin
            check_val("alu_issue", expect_issue(m_alu[best]), alu_issue_o);
        end
        check_val("mem_issue_valid", mem_ready(), mem_issue_valid_o);
        if (mem_ready()) begin
            check_val("mem_issue", expect_issue(m_mem[0]), mem_issue_o);
        end
    endtask

    task automatic advance_model();
        logic               acc;
        int                 best;
        logic [KEY_LEN-1:0] best_key;
        int                 free_idx [$];
        best = oldest_alu();
        best_key = age_key(m_alu[best]);
        acc = !st && !kl && model_alloc();
        for (int i = 0; i < ALU_ENT_NUM; i++) begin
            if (!m_alu[i].busy) begin
                free_idx.push_back(i);
            end
        end
        if (!best_key[KEY_LEN-1]) begin
            m_alu[best].busy = 1'b0;
        end
        if (mem_ready()) begin
            void'(m_mem.pop_front());
        end
        for (int i = 0; i < ALU_ENT_NUM; i++) begin
            m_alu[i].src1 = snoop(m_alu[i].src1, rs);
            m_alu[i].src2 = snoop(m_alu[i].src2, rs);
        end
        for (int i = 0; i < m_mem.size(); i++) begin
            m_mem[i].src1 = snoop(m_mem[i].src1, rs);
            m_mem[i].src2 = snoop(m_mem[i].src2, rs);
        end
        if (acc) begin
            if (s1.valid) begin
                if (s1.is_mem) begin
                    m_mem.push_back(new_entry(s1));
                end else begin
                    m_alu[free_idx.pop_front()] = new_entry(s1);
                end
            end
            if (s2.valid) begin
                if (s2.is_mem) begin
                    m_mem.push_back(new_entry(s2));
                end else begin
                    m_alu[free_idx.pop_front()] = new_entry(s2);
                end
            end
        end
        if (nrc) begin
            m_phase = ~m_phase;
        end
    endtask

    task automatic drive_next(int n);
        logic [31:0] v;
        s1 = rand_slot(tag_base, n < DISPATCH_CYCLES);
        s2 = rand_slot(tag_base + 6'd1, n < DISPATCH_CYCLES);
        // last pair before the tag wrap
        nrc = tag_base == 6'd62;
        tag_base = tag_base + 6'd2;
        st = take_bits(3) == 0;
        kl = take_bits(4) == 0;
        for (int b = 0; b < RESULT_BUS_NUM; b++) begin
            rs[b].valid = take_bits(1) != 0;
            v = take_bits(6);
            rs[b].tag = v[5:0];
            rs[b].data = take_bits(32);
        end
        // one bus per tag
        if (rs[0].valid && rs[1].tag == rs[0].tag) begin
            rs[1].valid = 1'b0;
        end
        dp_slot_1_i <= s1;
        dp_slot_2_i <= s2;
        stall_dp_i <= st;
        kill_dp_i <= kl;
        next_rrf_cycle_i <= nrc;
        exe_result_i <= rs;
    endtask

    function automatic logic model_empty();
        logic any_busy;
        any_busy = 1'b0;
        for (int i = 0; i < ALU_ENT_NUM; i++) begin
            any_busy |= m_alu[i].busy;
        end
        return !any_busy && m_mem.size() == 0;
    endfunction

    initial begin
        int n;
        lfsr = 32'hda13;
        tag_base = '0;
        m_phase = 1'b0;
        n = 0;
        s1 = '0;
        s2 = '0;
        st = 1'b0;
        kl = 1'b0;
        nrc = 1'b0;
        rs = '0;
        for (int i = 0; i < ALU_ENT_NUM; i++) begin
            m_alu[i] = '0;
        end
        reset_i = 1'b1;
        dp_slot_1_i = '0;
        dp_slot_2_i = '0;
        stall_dp_i = 1'b0;
        kill_dp_i = 1'b0;
        next_rrf_cycle_i = 1'b0;
        exe_result_i = '0;
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;
        while (!(n > DISPATCH_CYCLES && model_empty())) begin
            @(negedge clk_i);
            check_outputs();
            @(posedge clk_i);
            advance_model();
            drive_next(n);
            n++;
        end
        @(negedge clk_i);
        check_outputs();
        $display("test passed");
        $finish;
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("run did not drain within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/sw_cfg_pkg.sv
verilog/sw_types_pkg.sv
verilog/alloc_unit.sv
verilog/oldest_finder.sv
verilog/rs_alu.sv
verilog/rs_mem.sv
verilog/sw_unit.sv
testbench/sw_unit_checker.sv
testbench/tb_sw_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sw_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sw_unit -f src.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
